// File: mipsPkg.sv
package mipsPkg;

    localparam int WordWidth = 32;

    // One instruction word with two field layouts
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rFields;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } iFields;
    } instrWord;

    localparam logic [5:0] OpSpecial  = 6'h00;
    localparam logic [5:0] OpSpecial2 = 6'h1C;
    localparam logic [5:0] OpAddi     = 6'h08;
    localparam logic [5:0] OpAddiu    = 6'h09;
    localparam logic [5:0] OpSlti     = 6'h0A;
    localparam logic [5:0] OpSltiu    = 6'h0B;
    localparam logic [5:0] OpAndi     = 6'h0C;
    localparam logic [5:0] OpOri      = 6'h0D;
    localparam logic [5:0] OpXori     = 6'h0E;
    localparam logic [5:0] OpLui      = 6'h0F;

    localparam logic [5:0] FnSll   = 6'h00;
    localparam logic [5:0] FnSrl   = 6'h02;
    localparam logic [5:0] FnSra   = 6'h03;
    localparam logic [5:0] FnSllv  = 6'h04;
    localparam logic [5:0] FnSrlv  = 6'h06;
    localparam logic [5:0] FnSrav  = 6'h07;
    localparam logic [5:0] FnMfhi  = 6'h10;
    localparam logic [5:0] FnMflo  = 6'h12;
    localparam logic [5:0] FnMultu = 6'h19;
    localparam logic [5:0] FnDivu  = 6'h1B;
    localparam logic [5:0] FnAdd   = 6'h20;
    localparam logic [5:0] FnAddu  = 6'h21;
    localparam logic [5:0] FnSub   = 6'h22;
    localparam logic [5:0] FnSubu  = 6'h23;
    localparam logic [5:0] FnAnd   = 6'h24;
    localparam logic [5:0] FnOr    = 6'h25;
    localparam logic [5:0] FnXor   = 6'h26;
    localparam logic [5:0] FnNor   = 6'h27;
    localparam logic [5:0] FnSlt   = 6'h2A;
    localparam logic [5:0] FnSltu  = 6'h2B;
    localparam logic [5:0] FnClz   = 6'h20; // SPECIAL2
    localparam logic [5:0] FnClo   = 6'h21; // SPECIAL2

    localparam logic [3:0] AluAdd   = 4'd0;
    localparam logic [3:0] AluSub   = 4'd1;
    localparam logic [3:0] AluAnd   = 4'd2;
    localparam logic [3:0] AluOr    = 4'd3;
    localparam logic [3:0] AluXor   = 4'd4;
    localparam logic [3:0] AluNor   = 4'd5;
    localparam logic [3:0] AluSll   = 4'd6;
    localparam logic [3:0] AluSra   = 4'd7;
    localparam logic [3:0] AluSrl   = 4'd8;
    localparam logic [3:0] AluLui   = 4'd9;
    localparam logic [3:0] AluLt    = 4'd10;
    localparam logic [3:0] AluLtu   = 4'd11;
    localparam logic [3:0] AluClo   = 4'd12;
    localparam logic [3:0] AluClz   = 4'd13;
    localparam logic [3:0] AluPassA = 4'd14;

    localparam logic [1:0] MdNone  = 2'd0;
    localparam logic [1:0] MdMultu = 2'd1;
    localparam logic [1:0] MdDivu  = 2'd2;

    localparam logic [1:0] RdNone = 2'd0; // HI/LO read select
    localparam logic [1:0] RdHi   = 2'd1;
    localparam logic [1:0] RdLo   = 2'd2;

    localparam logic [1:0] SrcBRt   = 2'd0;
    localparam logic [1:0] SrcBSext = 2'd1;
    localparam logic [1:0] SrcBZext = 2'd2;

    localparam int DivCycles = 32;

endpackage

// File: leadingCounter.sv
module leadingCounter
    import mipsPkg::*;
(
    input  logic [WordWidth-1:0] value,
    input  logic                 countOnes,
    output logic [5:0]           count
);
    logic [31:0] v;
    logic [15:0] val16;
    logic [7:0]  val8;
    logic [3:0]  val4;

    assign v = countOnes ? ~value : value; // Leading ones become leading zeros

    assign count[5] = (v == 32'b0);
    assign count[4] = (v[31:16] == 16'b0) & ~count[5];
    assign val16    = count[4] ? v[15:0] : v[31:16];
    assign count[3] = (val16[15:8] == 8'b0) & ~count[5];
    assign val8     = count[3] ? val16[7:0] : val16[15:8];
    assign count[2] = (val8[7:4] == 4'b0) & ~count[5];
    assign val4     = count[2] ? val8[3:0] : val8[7:4];
    assign count[1] = (val4[3:2] == 2'b0) & ~count[5];
    assign count[0] = count[1] ? (~val4[1] & ~count[5]) : (~val4[3] & ~count[5]);

endmodule

// File: alu.sv
module alu
    import mipsPkg::*;
(
    input  logic [WordWidth-1:0] srcA,
    input  logic [WordWidth-1:0] srcB,
    input  logic [3:0]           aluCtrl,
    input  logic                 ignoreOvf,
    output logic [WordWidth-1:0] aluRes,
    output logic                 ovf
);
    logic [WordWidth:0] addWide;
    logic [WordWidth:0] subWide;
    logic [5:0]         zeroCount;
    logic [5:0]         oneCount;
    logic               addOvf;
    logic               subOvf;

    // Sign-extended by one bit for overflow detection
    assign addWide = {srcA[WordWidth-1], srcA} + {srcB[WordWidth-1], srcB};
    assign subWide = {srcA[WordWidth-1], srcA} - {srcB[WordWidth-1], srcB};

    leadingCounter i_zeroCounter (
        .value     (srcA),
        .countOnes (1'b0),
        .count     (zeroCount)
    );

    leadingCounter i_oneCounter (
        .value     (srcA),
        .countOnes (1'b1),
        .count     (oneCount)
    );

    always_comb
    begin
        case (aluCtrl)
            AluAdd:  aluRes = addWide[WordWidth-1:0]; // Wrapped even on overflow
            AluSub:  aluRes = subWide[WordWidth-1:0];
            AluAnd:  aluRes = srcA & srcB;
            AluOr:   aluRes = srcA | srcB;
            AluXor:  aluRes = srcA ^ srcB;
            AluNor:  aluRes = ~(srcA | srcB);
            AluSll:  aluRes = srcB << srcA[4:0]; // Amount in A, value in B
            AluSra:  aluRes = $signed(srcB) >>> srcA[4:0];
            AluSrl:  aluRes = srcB >> srcA[4:0];
            AluLui:  aluRes = {srcB[15:0], 16'b0};
            AluLt:   aluRes = {{(WordWidth-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            AluLtu:  aluRes = {{(WordWidth-1){1'b0}}, srcA < srcB};
            AluClo:  aluRes = {{(WordWidth-6){1'b0}}, oneCount};
            AluClz:  aluRes = {{(WordWidth-6){1'b0}}, zeroCount};
            default: aluRes = srcA;
        endcase
    end

    assign addOvf = (aluCtrl == AluAdd) && (addWide[WordWidth] != addWide[WordWidth-1]);
    assign subOvf = (aluCtrl == AluSub) && (subWide[WordWidth] != subWide[WordWidth-1]);
    assign ovf    = !ignoreOvf && (addOvf || subOvf);

endmodule

// File: aluDecoder.sv
module aluDecoder
    import mipsPkg::*;
(
    input  instrWord   instr,
    output logic [3:0] aluCtrl,
    output logic       srcASel,
    output logic [1:0] srcBSel,
    output logic       ignoreOvf,
    output logic [1:0] mdCmd,
    output logic [1:0] mdRead,
    output logic       illegal
);
    logic [5:0] opcode;
    logic [5:0] funct;
    logic       isSpecial;

    assign opcode    = instr.rFields.opcode;
    assign funct     = instr.rFields.funct;
    assign isSpecial = (opcode == OpSpecial);

    assign srcASel   = isSpecial && (funct inside {FnSll, FnSrl, FnSra}); // Shift by shamt
    assign ignoreOvf = (isSpecial && (funct inside {FnAddu, FnSubu})) || (opcode == OpAddiu);

    always_comb
    begin
        if (opcode inside {OpAndi, OpOri, OpXori})
            srcBSel = SrcBZext;
        else if (isSpecial || opcode == OpSpecial2)
            srcBSel = SrcBRt;
        else
            srcBSel = SrcBSext;
    end

    always_comb
    begin
        aluCtrl = AluPassA;
        mdCmd   = MdNone;
        mdRead  = RdNone;
        illegal = 1'b0;
        case (opcode)
            OpSpecial:
            begin
                case (funct)
                    FnSll, FnSllv:  aluCtrl = AluSll;
                    FnSrl, FnSrlv:  aluCtrl = AluSrl;
                    FnSra, FnSrav:  aluCtrl = AluSra;
                    FnMfhi:         mdRead  = RdHi;
                    FnMflo:         mdRead  = RdLo;
                    FnMultu:        mdCmd   = MdMultu;
                    FnDivu:         mdCmd   = MdDivu;
                    FnAdd, FnAddu:  aluCtrl = AluAdd;
                    FnSub, FnSubu:  aluCtrl = AluSub;
                    FnAnd:          aluCtrl = AluAnd;
                    FnOr:           aluCtrl = AluOr;
                    FnXor:          aluCtrl = AluXor;
                    FnNor:          aluCtrl = AluNor;
                    FnSlt:          aluCtrl = AluLt;
                    FnSltu:         aluCtrl = AluLtu;
                    default:        illegal = 1'b1;
                endcase
            end
            OpSpecial2:
            begin
                case (funct)
                    FnClz:   aluCtrl = AluClz;
                    FnClo:   aluCtrl = AluClo;
                    default: illegal = 1'b1;
                endcase
            end
            OpAddi, OpAddiu: aluCtrl = AluAdd;
            OpSlti:          aluCtrl = AluLt;
            OpSltiu:         aluCtrl = AluLtu;
            OpAndi:          aluCtrl = AluAnd;
            OpOri:           aluCtrl = AluOr;
            OpXori:          aluCtrl = AluXor;
            OpLui:           aluCtrl = AluLui; // Uses imm low half only
            default:         illegal = 1'b1;
        endcase
    end

endmodule

// File: mulDivUnit.sv
module mulDivUnit
    import mipsPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mdStart,
    input  logic [1:0]           mdCmd,
    input  logic [WordWidth-1:0] a,
    input  logic [WordWidth-1:0] b,
    output logic                 mdDone,
    output logic [WordWidth-1:0] hi,
    output logic [WordWidth-1:0] lo
);
    logic                 busy;
    logic [5:0]           divCount;
    logic [WordWidth-1:0] remReg;
    logic [WordWidth-1:0] quoReg;
    logic [WordWidth-1:0] divisorReg;
    logic [WordWidth-1:0] stepRem;
    logic [WordWidth-1:0] stepQuo;
    logic [WordWidth-1:0] stepDivisor;
    logic [WordWidth:0]   shifted;
    logic [WordWidth:0]   diff;
    logic                 fits;
    logic [WordWidth-1:0] nextRem;
    logic [WordWidth-1:0] nextQuo;
    logic                 divStart;

    assign divStart = mdStart && (mdCmd == MdDivu);

    // First step runs on the start cycle itself
    assign stepRem     = busy ? remReg : '0;
    assign stepQuo     = busy ? quoReg : a;
    assign stepDivisor = busy ? divisorReg : b;

    assign shifted = {stepRem, stepQuo[WordWidth-1]};
    assign diff    = shifted - {1'b0, stepDivisor};
    assign fits    = (shifted >= {1'b0, stepDivisor});
    assign nextRem = fits ? diff[WordWidth-1:0] : shifted[WordWidth-1:0];
    assign nextQuo = {stepQuo[WordWidth-2:0], fits};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy     <= 1'b0;
            divCount <= '0;
            mdDone   <= 1'b0;
            hi       <= '0;
            lo       <= '0;
        end
        else
        begin
            mdDone <= 1'b0;
            if (mdStart && mdCmd == MdMultu)
            begin
                {hi, lo} <= {{WordWidth{1'b0}}, a} * {{WordWidth{1'b0}}, b};
                mdDone   <= 1'b1;
            end
            else if (divStart)
            begin
                busy     <= 1'b1;
                divCount <= 6'd1;
            end
            else if (busy)
            begin
                divCount <= divCount + 6'd1;
                if (divCount == 6'(DivCycles - 1)) // Last step
                begin
                    busy   <= 1'b0;
                    hi     <= nextRem;
                    lo     <= nextQuo;
                    mdDone <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (divStart || busy)
        begin
            remReg <= nextRem;
            quoReg <= nextQuo;
        end
        if (divStart)
            divisorReg <= b;
    end

    // The stage must hold off new commands until the divide retires
    assert property (@(posedge clk) disable iff (rst) mdStart |-> !busy);

endmodule

// File: exeStage.sv
module exeStage
    import mipsPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 inValid,
    output logic                 inReady,
    input  instrWord             instr,
    input  logic [WordWidth-1:0] rsVal,
    input  logic [WordWidth-1:0] rtVal,
    output logic                 outValid,
    input  logic                 outReady,
    output logic [WordWidth-1:0] result,
    output logic                 overflow,
    output logic                 illegal
);
    logic [3:0]           aluCtrl;
    logic                 srcASel;
    logic [1:0]           srcBSel;
    logic                 ignoreOvf;
    logic [1:0]           mdCmd;
    logic [1:0]           mdRead;
    logic                 decIllegal;
    logic [WordWidth-1:0] srcA;
    logic [WordWidth-1:0] srcB;
    logic [WordWidth-1:0] aluRes;
    logic                 aluOvf;
    logic [WordWidth-1:0] hi;
    logic [WordWidth-1:0] lo;
    logic [WordWidth-1:0] selRes;
    logic                 mdStart;
    logic                 mdDone;
    logic                 mdPending;
    logic                 accept;
    logic                 aluAccept;

    aluDecoder i_decoder (
        .instr     (instr),
        .aluCtrl   (aluCtrl),
        .srcASel   (srcASel),
        .srcBSel   (srcBSel),
        .ignoreOvf (ignoreOvf),
        .mdCmd     (mdCmd),
        .mdRead    (mdRead),
        .illegal   (decIllegal)
    );

    assign srcA = srcASel ? {{(WordWidth-5){1'b0}}, instr.rFields.shamt} : rsVal;

    always_comb
    begin
        case (srcBSel)
            SrcBSext: srcB = {{(WordWidth-16){instr.iFields.imm[15]}}, instr.iFields.imm};
            SrcBZext: srcB = {{(WordWidth-16){1'b0}}, instr.iFields.imm};
            default:  srcB = rtVal;
        endcase
    end

    alu i_alu (
        .srcA      (srcA),
        .srcB      (srcB),
        .aluCtrl   (aluCtrl),
        .ignoreOvf (ignoreOvf),
        .aluRes    (aluRes),
        .ovf       (aluOvf)
    );

    mulDivUnit i_mulDiv (
        .clk     (clk),
        .rst     (rst),
        .mdStart (mdStart),
        .mdCmd   (mdCmd),
        .a       (rsVal),
        .b       (rtVal),
        .mdDone  (mdDone),
        .hi      (hi),
        .lo      (lo)
    );

    assign inReady   = (!outValid || outReady) && !mdPending; // Drain and accept together
    assign accept    = inValid && inReady;
    assign mdStart   = accept && (mdCmd != MdNone);
    assign aluAccept = accept && (mdCmd == MdNone);

    always_comb
    begin
        case (mdRead)
            RdHi:    selRes = hi;
            RdLo:    selRes = lo;
            default: selRes = aluRes;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            outValid  <= 1'b0;
            mdPending <= 1'b0;
        end
        else
        begin
            if (mdStart)
                mdPending <= 1'b1;
            else if (mdDone)
                mdPending <= 1'b0;
            if (aluAccept || mdDone)
                outValid <= 1'b1;
            else if (outReady)
                outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (mdDone) // MULTU/DIVU retire with an empty result
        begin
            result   <= '0;
            overflow <= 1'b0;
            illegal  <= 1'b0;
        end
        else if (aluAccept)
        begin
            result   <= selRes;
            overflow <= aluOvf;
            illegal  <= decIllegal;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        outValid && !outReady |=> outValid && $stable(result) && $stable(overflow)
            && $stable(illegal));

endmodule

// File: exeRefModel.svh
logic [31:0] modelHi = '0;
logic [31:0] modelLo = '0;

function automatic int leadingRun(input logic [31:0] w, input logic bitVal);
    int n;
    n = 0;
    while (n < 32 && w[31 - n] == bitVal)
        n++;
    return n;
endfunction

// Expected outcome of one accepted instruction with the HI/LO model
function automatic void predictResult(input logic [31:0] ins, input logic [31:0] a,
    input logic [31:0] b, output logic [31:0] res, output logic ovf, output logic ill);
    logic [5:0]  op;
    logic [5:0]  fn;
    logic [4:0]  sa;
    logic [31:0] se;
    logic [31:0] ze;
    op  = ins[31:26];
    fn  = ins[5:0];
    sa  = ins[10:6];
    se  = {{16{ins[15]}}, ins[15:0]};
    ze  = {16'b0, ins[15:0]};
    res = a;
    ovf = 1'b0;
    ill = 1'b0;
    if (op == OpSpecial)
    begin
        case (fn)
            FnSll:  res = b << sa;
            FnSrl:  res = b >> sa;
            FnSra:  res = $signed(b) >>> sa;
            FnSllv: res = b << a[4:0];
            FnSrlv: res = b >> a[4:0];
            FnSrav: res = $signed(b) >>> a[4:0];
            FnMfhi: res = modelHi;
            FnMflo: res = modelLo;
            FnMultu:
            begin
                {modelHi, modelLo} = 64'(a) * 64'(b);
                res = '0;
            end
            FnDivu:
            begin
                modelHi = (b == 0) ? a : a % b; // Zero divisor leaves dividend in HI
                modelLo = (b == 0) ? '1 : a / b;
                res = '0;
            end
            FnAdd, FnAddu:
            begin
                res = a + b;
                ovf = (fn == FnAdd) && (a[31] == b[31]) && (res[31] != a[31]);
            end
            FnSub, FnSubu:
            begin
                res = a - b;
                ovf = (fn == FnSub) && (a[31] != b[31]) && (res[31] != a[31]);
            end
            FnAnd:   res = a & b;
            FnOr:    res = a | b;
            FnXor:   res = a ^ b;
            FnNor:   res = ~(a | b);
            FnSlt:   res = 32'($signed(a) < $signed(b));
            FnSltu:  res = 32'(a < b);
            default: ill = 1'b1;
        endcase
    end
    else if (op == OpSpecial2)
    begin
        case (fn)
            FnClz:   res = leadingRun(a, 1'b0);
            FnClo:   res = leadingRun(a, 1'b1);
            default: ill = 1'b1;
        endcase
    end
    else
    begin
        case (op)
            OpAddi, OpAddiu:
            begin
                res = a + se;
                ovf = (op == OpAddi) && (a[31] == se[31]) && (res[31] != a[31]);
            end
            OpSlti:  res = 32'($signed(a) < $signed(se));
            OpSltiu: res = 32'(a < se);
            OpAndi:  res = a & ze;
            OpOri:   res = a | ze;
            OpXori:  res = a ^ ze;
            OpLui:   res = {ins[15:0], 16'b0};
            default: ill = 1'b1;
        endcase
    end
endfunction

// File: exeStageTb.sv
module exeStageTb
    import mipsPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NumInstr   = 382; // Sum over all test sections
    localparam int CycleLimit = NumInstr * 40 + 200;

    localparam logic [71:0] AluFns = {FnSll, FnSrl, FnSra, FnSllv, FnSrlv, FnSrav,
                                      FnAnd, FnOr, FnXor, FnNor, FnSlt, FnSltu};
    localparam logic [35:0] AluOps   = {OpAndi, OpOri, OpXori, OpLui, OpSlti, OpSltiu};
    localparam logic [23:0] ArithFns = {FnAdd, FnAddu, FnSub, FnSubu};
    localparam logic [23:0] MdFns    = {FnMultu, FnDivu, FnMfhi, FnMflo};
    localparam logic [23:0] BadOps   = {6'h02, 6'h04, 6'h23, 6'h2B};
    localparam logic [23:0] BadFns   = {6'h01, 6'h05, 6'h18, 6'h1A};
    localparam logic [23:0] BadFns2  = {6'h00, 6'h02, 6'h04, 6'h3F}; // Under SPECIAL2
    // Operand pairs around the signed limits with rs in the upper word
    localparam logic [511:0] OvfPairs = {
        64'h7FFFFFFF_00000001, 64'h80000000_FFFFFFFF,
        64'h7FFFFFFF_7FFFFFFF, 64'h80000000_80000000,
        64'h80000000_00000001, 64'h7FFFFFFF_FFFFFFFF,
        64'h00000000_80000000, 64'h40000000_40000000
    };

    logic        clk;
    logic        rst;
    logic        inValid;
    logic        inReady;
    instrWord    instr;
    logic [31:0] rsVal;
    logic [31:0] rtVal;
    logic        outValid;
    logic        outReady;
    logic [31:0] result;
    logic        overflow;
    logic        illegal;

    logic [33:0] expQ[$]; // {result, overflow, illegal}
    string       nameQ[$];
    string       testName;
    int          sent;
    int          received;
    int          valueErrs;
    int          flowErrs;
    int          cycles;

    `include "exeRefModel.svh"

    exeStage i_dut (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .inReady  (inReady),
        .instr    (instr),
        .rsVal    (rsVal),
        .rtVal    (rtVal),
        .outValid (outValid),
        .outReady (outReady),
        .result   (result),
        .overflow (overflow),
        .illegal  (illegal)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        outReady = 1'b0;
        forever
        begin
            @(negedge clk);
            outReady = ($urandom % 4) != 0; // Low about a quarter of the time
        end
    end

    initial
    begin
        cycles = 0;
        while (cycles < CycleLimit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, %0d of %0d outputs seen", cycles, received, sent);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    always @(posedge clk)
    begin
        if (!rst && outValid && outReady)
            checkOutput();
    end

    task automatic checkOutput();
        logic [33:0] expWord;
        string       name;
        if (expQ.size() == 0)
        begin
            flowErrs++;
            $display("Output transfer with no accepted instruction waiting for it");
        end
        else
        begin
            expWord = expQ.pop_front();
            name    = nameQ.pop_front();
            received++;
            if (result !== expWord[33:2])
            begin
                valueErrs++;
                $display("Error %s: result expected %h, actual %h", name, expWord[33:2], result);
            end
            if (overflow !== expWord[1])
            begin
                valueErrs++;
                $display("Error %s: overflow expected %b, actual %b", name, expWord[1], overflow);
            end
            if (illegal !== expWord[0])
            begin
                valueErrs++;
                $display("Error %s: illegal expected %b, actual %b", name, expWord[0], illegal);
            end
        end
    endtask

    function automatic logic [31:0] rType(input logic [5:0] op, input logic [5:0] fn);
        logic [31:0] r;
        r = $urandom;
        return {op, r[19:0], fn}; // Random rs, rt, rd and shamt
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [15:0] imm);
        logic [31:0] r;
        r = $urandom;
        return {op, r[9:0], imm};
    endfunction

    function automatic logic [31:0] randomAluInstr();
        int k;
        k = $urandom % 18;
        if (k < 12)
            return rType(OpSpecial, AluFns[k*6 +: 6]);
        else
            return iType(AluOps[(k-12)*6 +: 6], 16'($urandom));
    endfunction

    function automatic logic [31:0] arithInstr(input int k, input logic [15:0] imm);
        if (k < 4)
            return rType(OpSpecial, ArithFns[k*6 +: 6]);
        else
            return iType((k == 4) ? OpAddi : OpAddiu, imm);
    endfunction

    function automatic logic [31:0] randomIllegalInstr();
        int k;
        k = $urandom % 12;
        if (k < 4)
            return iType(BadOps[k*6 +: 6], 16'($urandom));
        else if (k < 8)
            return rType(OpSpecial, BadFns[(k-4)*6 +: 6]);
        else
            return rType(OpSpecial2, BadFns2[(k-8)*6 +: 6]);
    endfunction

    // Holds the transfer until accepted, then logs the prediction
    task automatic sendInstr(input logic [31:0] ins, input logic [31:0] a,
        input logic [31:0] b);
        logic [31:0] expRes;
        logic        expOvf;
        logic        expIll;
        @(negedge clk);
        inValid = 1'b1;
        instr   = ins;
        rsVal   = a;
        rtVal   = b;
        @(posedge clk);
        while (!inReady)
            @(posedge clk);
        predictResult(ins, a, b, expRes, expOvf, expIll);
        expQ.push_back({expRes, expOvf, expIll});
        nameQ.push_back(testName);
        sent++;
    endtask

    task automatic logicOps();
        testName = "logic/shift/lui/slt";
        for (int i = 0; i < 80; i++)
            sendInstr(randomAluInstr(), $urandom, $urandom);
    endtask

    task automatic overflowEdges();
        logic [63:0] pair;
        testName = "add/sub overflow";
        for (int p = 0; p < 8; p++)
        begin
            pair = OvfPairs[p*64 +: 64];
            for (int k = 0; k < 6; k++)
                sendInstr(arithInstr(k, pair[15:0]), pair[63:32], pair[31:0]);
        end
    endtask

    task automatic leadingCounts();
        logic [31:0] w;
        testName = "clz/clo";
        for (int i = 0; i < 12; i++)
        begin
            if (i == 0)
                w = '0;
            else if (i == 1)
                w = '1;
            else
            begin
                w = $urandom >> ($urandom % 32); // Varied run lengths
                if (i % 2 == 1)
                    w = ~w;
            end
            sendInstr(rType(OpSpecial2, FnClz), w, $urandom);
            sendInstr(rType(OpSpecial2, FnClo), w, $urandom);
        end
    endtask

    task automatic mulDivSequence();
        logic [31:0] a;
        logic [31:0] b;
        logic [5:0]  fn;
        testName = "multu/divu hi/lo";
        for (int i = 0; i < 6; i++)
        begin
            a  = $urandom;
            b  = $urandom;
            fn = (i % 2 == 0) ? FnMultu : FnDivu;
            case (i)
                1: b = b >> ($urandom % 32);
                2:
                begin
                    a = '1;
                    b = '1;
                end
                3: b = '0; // Divide by zero
                4: a = '0;
                5: a = a >> 28;
                default: ;
            endcase
            sendInstr(rType(OpSpecial, fn), a, b);
            sendInstr(rType(OpSpecial, FnMfhi), $urandom, $urandom);
            sendInstr(rType(OpSpecial, FnMflo), $urandom, $urandom);
        end
    endtask

    task automatic illegalEncodings();
        testName = "illegal";
        for (int i = 0; i < 12; i++)
            sendInstr(randomIllegalInstr(), $urandom, $urandom);
    endtask

    task automatic mixedStream();
        int          kind;
        logic [31:0] a;
        logic [31:0] ins;
        testName = "mixed stream";
        for (int i = 0; i < 200; i++)
        begin
            kind = $urandom % 10;
            a    = $urandom;
            if (kind < 6)
                ins = randomAluInstr();
            else if (kind == 6)
                ins = arithInstr($urandom % 6, 16'($urandom));
            else if (kind == 7)
            begin
                ins = rType(OpSpecial2, ($urandom % 2 == 1) ? FnClo : FnClz);
                a   = a >> ($urandom % 32);
            end
            else if (kind == 8)
                ins = rType(OpSpecial, MdFns[($urandom % 4)*6 +: 6]);
            else
                ins = randomIllegalInstr();
            if ($urandom % 8 == 0)
            begin
                @(negedge clk); // Idle cycle on the input
                inValid = 1'b0;
            end
            sendInstr(ins, a, $urandom);
        end
    endtask

    initial
    begin
        void'($urandom(32'h19e3d061));
        rst       = 1'b1;
        inValid   = 1'b0;
        instr     = '0;
        rsVal     = '0;
        rtVal     = '0;
        sent      = 0;
        received  = 0;
        valueErrs = 0;
        flowErrs  = 0;
        testName  = "reset";
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        logicOps();
        overflowEdges();
        leadingCounts();
        mulDivSequence();
        illegalEncodings();
        mixedStream();
        @(negedge clk);
        inValid = 1'b0;
        while (received != sent)
            @(posedge clk);
        repeat (5) @(posedge clk); // Catch any extra output
        $display("Outputs checked %0d of %0d, value errors %0d, flow errors %0d",
            received, sent, valueErrs, flowErrs);
        if (valueErrs == 0 && flowErrs == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: project.f
+incdir+.
mipsPkg.sv
leadingCounter.sv
alu.sv
aluDecoder.sv
mulDivUnit.sv
exeStage.sv
exeStageTb.sv

// File: Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      ?= exeStageTb
FILELIST ?= project.f
BUILDDIR ?= obj_dir
LOG      ?= sim.log
PASS     := TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR) -o $(TOP)
	./$(BUILDDIR)/$(TOP) | tee $(LOG)
	@grep -qF "$(PASS)" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILDDIR) $(LOG)
